/* tb.f */
verilog/pipe_ctrl_pkg.sv
verilog/pc_reg.sv
verilog/hdu.sv
verilog/clint.sv
verilog/ctrl.sv
verilog/pipe_ctrl_top.sv
test/pipe_ctrl_props.sv
test/tb_pipe_ctrl.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the pipeline control testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timing --timescale 1ns/1ps -f tb.f \
        --top-module tb_pipe_ctrl -o sim_pipe_ctrl; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_pipe_ctrl)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^SIMULATION PASSED$"; then
    exit 0
fi
exit 1

/* test/tb_pipe_ctrl.sv */
// pipeline control testbench
module tb_pipe_ctrl
    import pipe_ctrl_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam inst_addr_t RESET_ADDR   = 32'h0000_1000;
    localparam inst_addr_t TRAP_VEC     = 32'h0000_0800;
    localparam int         JUMP_TIMEOUT = 20;

    // one cycle of stimulus and the response it should give
    typedef struct packed {
        logic       jump;
        inst_addr_t jaddr;
        logic       stall_ex;
        logic       is_load;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic       irq;
        logic       mret;
        cu_bus_t    exp_bus;
        logic       exp_jump;
        inst_addr_t exp_addr;
    } row_t;

    logic        clk = 1'b0;
    logic        reset_i;
    logic        jump_flag_i;
    inst_addr_t  jump_addr_i;
    logic        stall_flag_ex_i;
    logic        atom_opt_busy_i;
    logic        ex_is_load_i;
    reg_idx_t    ex_rd_i;
    reg_idx_t    id_rs1_i;
    reg_idx_t    id_rs2_i;
    logic        irq_i;
    logic        irq_en_i;
    logic        mret_i;
    inst_addr_t  pc_o;
    cu_bus_t     stall_flag_o;
    logic        jump_flag_o;
    inst_addr_t  jump_addr_o;

    row_t        rows[$];
    inst_addr_t  model_pc;
    int          mismatch_cnt = 0;
    int          fail_cnt = 0;
    int unsigned seed_val;
    logic        got_jump;
    logic        seen_flush;

    pipe_ctrl_top #(
        .RESET_ADDR(RESET_ADDR),
        .TRAP_VEC  (TRAP_VEC)
    ) i_dut (.*);

    always #10 clk = ~clk;

    function automatic void push_row(input logic j, input inst_addr_t ja, input logic sx,
            input logic ld, input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2,
            input logic irq, input logic mret, input cu_bus_t eb, input logic ej,
            input inst_addr_t ea);
        rows.push_back(row_t'{j, ja, sx, ld, rd, rs1, rs2, irq, mret, eb, ej, ea});
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
        mismatch_cnt++;
    endtask

    // drive on the falling edge, check mid low phase
    task automatic apply_row(input row_t r);
        jump_flag_i     = r.jump;
        jump_addr_i     = r.jump ? r.jaddr : $urandom;
        stall_flag_ex_i = r.stall_ex;
        ex_is_load_i    = r.is_load;
        ex_rd_i         = r.rd;
        id_rs1_i        = r.rs1;
        id_rs2_i        = r.rs2;
        irq_i           = r.irq;
        mret_i          = r.mret;
        #5;
        if (stall_flag_o !== r.exp_bus) begin
            report_mismatch("stall_flag_o", 32'(stall_flag_o), 32'(r.exp_bus));
        end
        if (jump_flag_o !== r.exp_jump) begin
            report_mismatch("jump_flag_o", 32'(jump_flag_o), 32'(r.exp_jump));
        end
        if (r.exp_jump && jump_addr_o !== r.exp_addr) begin
            report_mismatch("jump_addr_o", jump_addr_o, r.exp_addr);
        end
        if (pc_o !== model_pc) begin
            report_mismatch("pc_o", pc_o, model_pc);
        end
        // model pc: jump, else hold, else step
        if (r.exp_jump) begin
            model_pc = r.exp_addr;
        end else if (!r.exp_bus[CU_STALL]) begin
            model_pc = model_pc + INST_BYTES;
        end
        @(negedge clk);
    endtask

    initial begin
        seed_val        = $urandom(32'h7a29);
        reset_i         = 1'b1;
        jump_flag_i     = 1'b0;
        jump_addr_i     = '0;
        stall_flag_ex_i = 1'b0;
        atom_opt_busy_i = 1'b0;
        ex_is_load_i    = 1'b0;
        ex_rd_i         = '0;
        id_rs1_i        = '0;
        id_rs2_i        = '0;
        irq_i           = 1'b0;
        irq_en_i        = 1'b1;
        mret_i          = 1'b0;
        model_pc        = RESET_ADDR;

        // jump jaddr stall load rd rs1 rs2 irq mret | bus jump addr
        // free run from reset
        push_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 3'b000, 0, 0);
        push_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 3'b000, 0, 0);
        push_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 3'b000, 0, 0);
        // execute jump, stall, then both
        push_row(1, 'h3000, 0, 0, 0, 0, 0, 0, 0, 3'b010, 1, 'h3000);
        push_row(0, 0, 1, 0, 0, 0, 0, 0, 0, 3'b101, 0, 0);
        push_row(0, 0, 1, 0, 0, 0, 0, 0, 0, 3'b101, 0, 0);
        push_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 3'b000, 0, 0);
        push_row(1, 'h4000, 1, 0, 0, 0, 0, 0, 0, 3'b111, 1, 'h4000);
        // load-use on rs1, rs2, then x0, non-load, jump
        push_row(0, 0, 0, 1, 5, 5, 3, 0, 0, 3'b001, 0, 0);
        push_row(0, 0, 0, 1, 7, 2, 7, 0, 0, 3'b001, 0, 0);
        push_row(0, 0, 0, 1, 0, 0, 0, 0, 0, 3'b000, 0, 0);
        push_row(0, 0, 0, 0, 5, 5, 0, 0, 0, 3'b000, 0, 0);
        push_row(1, 'h5000, 0, 1, 5, 5, 0, 0, 0, 3'b010, 1, 'h5000);
        // irq edge, flush, jump to vector
        push_row(0, 0, 0, 0, 0, 0, 0, 1, 0, 3'b000, 0, 0);
        push_row(0, 0, 0, 0, 0, 0, 0, 1, 0, 3'b010, 0, 0);
        push_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 3'b010, 1, TRAP_VEC);
        push_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 3'b000, 0, 0);
        // second edge inside the trap is masked
        push_row(0, 0, 0, 0, 0, 0, 0, 1, 0, 3'b000, 0, 0);
        push_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 3'b000, 0, 0);
        // mret returns to the pc seen in the entry flush cycle
        push_row(0, 0, 0, 0, 0, 0, 0, 0, 1, 3'b000, 0, 0);
        push_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 3'b010, 0, 0);
        push_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 3'b010, 1, 'h5004);
        push_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 3'b000, 0, 0);

        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end

        // irq while the atomic unit is busy must wait
        atom_opt_busy_i = 1'b1;
        irq_i           = 1'b1;
        repeat (6) begin
            #5;
            if (jump_flag_o !== 1'b0) begin
                report_mismatch("jump_flag_o", 32'(jump_flag_o), 32'h0);
            end
            if (stall_flag_o !== 3'b000) begin
                report_mismatch("stall_flag_o", 32'(stall_flag_o), 32'h0);
            end
            @(negedge clk);
        end
        atom_opt_busy_i = 1'b0;
        irq_i           = 1'b0;
        got_jump        = 1'b0;
        seen_flush      = 1'b0;
        for (int i = 0; i < JUMP_TIMEOUT && !got_jump; i++) begin
            #5;
            if (jump_flag_o === 1'b1) begin
                got_jump = 1'b1;
            end else begin
                seen_flush = seen_flush | stall_flag_o[CU_FLUSH];
                @(negedge clk);
            end
        end
        if (!got_jump) begin
            $display("no interrupt jump within %0d cycles after atomic busy fell",
                JUMP_TIMEOUT);
            fail_cnt++;
        end else begin
            if (jump_addr_o !== TRAP_VEC) begin
                report_mismatch("jump_addr_o", jump_addr_o, TRAP_VEC);
            end
            if (!seen_flush) begin
                $display("deferred interrupt jumped without a flush cycle before it");
                fail_cnt++;
            end
        end

        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* test/pipe_ctrl_props.sv */
// interrupt sequencer pulse checks
module pipe_ctrl_props
    import pipe_ctrl_pkg::*;
(
    input logic         clk,
    input logic         reset_i,
    input logic         flush_i,
    input logic         int_jump_i,
    input logic         atom_busy_i,
    input clint_state_t state_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // flush is a single-cycle pulse
    flush_single: assert property (@(posedge clk) disable iff (reset_i)
        flush_i |=> !flush_i)
        else $error("flush held high for two cycles");

    // the jump always comes right after the flush
    flush_then_jump: assert property (@(posedge clk) disable iff (reset_i)
        flush_i |=> int_jump_i)
        else $error("no interrupt jump in the cycle after flush");

    // never both at once
    no_overlap: assert property (@(posedge clk) disable iff (reset_i)
        !(flush_i && int_jump_i))
        else $error("flush and interrupt jump high together");

    // a request waits in idle while the atomic unit is busy
    busy_defers: assert property (@(posedge clk) disable iff (reset_i)
        (state_i == CLINT_IDLE && atom_busy_i) |=> state_i == CLINT_IDLE)
        else $error("sequence left idle while the atomic unit was busy");

endmodule

// attach to every clint instance
bind clint pipe_ctrl_props i_props (
    .clk        (clk),
    .reset_i    (reset_i),
    .flush_i    (flush_o),
    .int_jump_i (int_jump_o),
    .atom_busy_i(atom_opt_busy_i),
    .state_i    (state_q)
);

/* verilog/pipe_ctrl_top.sv */
// pipeline control subsystem top
module pipe_ctrl_top
    import pipe_ctrl_pkg::*;
#(
    parameter inst_addr_t RESET_ADDR = 32'h0000_0000,
    parameter inst_addr_t TRAP_VEC   = 32'h0000_0100
) (
    input  logic       clk,
    input  logic       reset_i,

    // execute stage results
    input  logic       jump_flag_i,
    input  inst_addr_t jump_addr_i,
    input  logic       stall_flag_ex_i,
    input  logic       atom_opt_busy_i,

    // hazard inputs
    input  logic       ex_is_load_i,
    input  reg_idx_t   ex_rd_i,
    input  reg_idx_t   id_rs1_i,
    input  reg_idx_t   id_rs2_i,

    // interrupt and trap return
    input  logic       irq_i,
    input  logic       irq_en_i,
    input  logic       mret_i,

    output inst_addr_t pc_o,
    output cu_bus_t    stall_flag_o,
    output logic       jump_flag_o,
    output inst_addr_t jump_addr_o
);

    // internal nets
    inst_addr_t pc;
    inst_addr_t int_addr;
    inst_addr_t jump_addr;
    cu_bus_t    stall_bus;
    logic       jump_flag;
    logic       int_jump;
    logic       flush_flag_clint;
    logic       stall_flag_hdu;

    // fetch address
    pc_reg #(
        .RESET_ADDR(RESET_ADDR)
    ) i_pc_reg (
        .clk        (clk),
        .reset_i    (reset_i),
        .jump_flag_i(jump_flag),
        .jump_addr_i(jump_addr),
        .hold_i     (stall_bus[CU_STALL]),
        .pc_o       (pc)
    );

    // load-use check
    hdu i_hdu (
        .ex_is_load_i(ex_is_load_i),
        .ex_rd_i     (ex_rd_i),
        .id_rs1_i    (id_rs1_i),
        .id_rs2_i    (id_rs2_i),
        .stall_flag_o(stall_flag_hdu)
    );

    // trap entry and exit
    clint #(
        .TRAP_VEC(TRAP_VEC)
    ) i_clint (
        .clk            (clk),
        .reset_i        (reset_i),
        .irq_i          (irq_i),
        .irq_en_i       (irq_en_i),
        .mret_i         (mret_i),
        .atom_opt_busy_i(atom_opt_busy_i),
        .pc_i           (pc),
        .flush_o        (flush_flag_clint),
        .int_jump_o     (int_jump),
        .int_addr_o     (int_addr)
    );

    // merge into the control bus
    ctrl i_ctrl (
        .jump_flag_i       (jump_flag_i),
        .jump_addr_i       (jump_addr_i),
        .stall_flag_ex_i   (stall_flag_ex_i),
        .int_jump_i        (int_jump),
        .int_addr_i        (int_addr),
        .flush_flag_clint_i(flush_flag_clint),
        .stall_flag_hdu_i  (stall_flag_hdu),
        .stall_flag_o      (stall_bus),
        .jump_flag_o       (jump_flag),
        .jump_addr_o       (jump_addr)
    );

    assign pc_o         = pc;
    assign stall_flag_o = stall_bus;
    assign jump_flag_o  = jump_flag;
    assign jump_addr_o  = jump_addr;

endmodule

/* verilog/ctrl.sv */
// pipeline control merge
module ctrl
    import pipe_ctrl_pkg::*;
(
    // from execute
    input  logic       jump_flag_i,
    input  inst_addr_t jump_addr_i,
    input  logic       stall_flag_ex_i,

    // from clint
    input  logic       int_jump_i,
    input  inst_addr_t int_addr_i,
    input  logic       flush_flag_clint_i,

    // from hdu
    input  logic       stall_flag_hdu_i,

    // to pipeline stages
    output cu_bus_t    stall_flag_o,

    // to pc_reg
    output logic       jump_flag_o,
    output inst_addr_t jump_addr_o
);

    logic hdu_stall;

    // either source redirects fetch
    assign jump_flag_o = jump_flag_i | int_jump_i;

    // interrupt target has priority
    assign jump_addr_o = int_jump_i ? int_addr_i : jump_addr_i;

    // hazard bubble is pointless when execute redirects anyway
    assign hdu_stall = stall_flag_hdu_i & ~jump_flag_i;

    // control bus bits
    assign stall_flag_o[CU_STALL]          = stall_flag_ex_i | hdu_stall;
    assign stall_flag_o[CU_FLUSH]          = jump_flag_o | flush_flag_clint_i;
    // dispatch only waits on multi-cycle execute
    assign stall_flag_o[CU_STALL_DISPATCH] = stall_flag_ex_i;

endmodule

/* verilog/clint.sv */
// interrupt and trap return sequencer
module clint
    import pipe_ctrl_pkg::*;
#(
    parameter inst_addr_t TRAP_VEC = 32'h0000_0100
) (
    input  logic       clk,
    input  logic       reset_i,

    // request sources
    input  logic       irq_i,
    input  logic       irq_en_i,
    input  logic       mret_i,

    // atomic op in flight, requests wait
    input  logic       atom_opt_busy_i,

    // current fetch pc, saved as mepc
    input  inst_addr_t pc_i,

    // to ctrl
    output logic       flush_o,
    output logic       int_jump_o,
    output inst_addr_t int_addr_o
);

    clint_state_t state_q;
    clint_state_t state_d;

    logic       irq_q;
    logic       irq_rise;
    logic       seq_busy;
    logic       irq_req;
    logic       mret_req;
    logic       any_req;
    logic       start;
    logic       pending_q;
    logic       pend_mret_q;
    logic       is_mret_q;
    logic       in_trap_q;
    inst_addr_t mepc_q;

    // rising edge on the external line
    assign irq_rise = irq_i & ~irq_q;

    // sequence already running or queued
    assign seq_busy = (state_q != CLINT_IDLE) | pending_q;

    // irq masked inside a trap, mret only valid inside one
    assign irq_req  = irq_rise & irq_en_i & ~in_trap_q & ~seq_busy;
    assign mret_req = mret_i & in_trap_q & ~seq_busy;
    assign any_req  = irq_req | mret_req;

    // leave idle once the atomic unit is quiet
    assign start = (state_q == CLINT_IDLE) & (pending_q | any_req) & ~atom_opt_busy_i;

    // next state, strict idle-flush-jump order
    always_comb begin
        state_d = state_q;
        case (state_q)
            CLINT_IDLE: begin
                if (start) begin
                    state_d = CLINT_FLUSH;
                end
            end
            CLINT_FLUSH: state_d = CLINT_JUMP;
            CLINT_JUMP:  state_d = CLINT_IDLE;
            default:     state_d = CLINT_IDLE;
        endcase
    end

    // control registers
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q     <= CLINT_IDLE;
            irq_q       <= 1'b0;
            pending_q   <= 1'b0;
            pend_mret_q <= 1'b0;
            is_mret_q   <= 1'b0;
            in_trap_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            irq_q   <= irq_i;
            // park a request that has to wait on atomic busy
            if (start) begin
                pending_q <= 1'b0;
            end else if (any_req) begin
                pending_q   <= 1'b1;
                pend_mret_q <= mret_req;
            end
            // latch the return type as the sequence starts
            if (start) begin
                is_mret_q <= pending_q ? pend_mret_q : mret_req;
            end
            // trap window opens at the jump, closes at the mret jump
            if (state_q == CLINT_JUMP) begin
                in_trap_q <= ~is_mret_q;
            end
        end
    end

    // interrupt entry saves the pc seen in the flush cycle
    always_ff @(posedge clk) begin
        if ((state_q == CLINT_FLUSH) && !is_mret_q) begin
            mepc_q <= pc_i;
        end
    end

    // one-cycle pulses decoded from state
    assign flush_o    = (state_q == CLINT_FLUSH);
    assign int_jump_o = (state_q == CLINT_JUMP);

    // Target is the vector on entry and the saved pc on return.
    assign int_addr_o = is_mret_q ? mepc_q : TRAP_VEC;

endmodule

/* verilog/hdu.sv */
// load-use hazard detection
module hdu
    import pipe_ctrl_pkg::*;
(
    // execute stage
    input  logic     ex_is_load_i,
    input  reg_idx_t ex_rd_i,

    // decode stage sources
    input  reg_idx_t id_rs1_i,
    input  reg_idx_t id_rs2_i,

    output logic     stall_flag_o
);

    logic rd_valid;
    logic rs1_hit;
    logic rs2_hit;

    // x0 never carries a dependency
    assign rd_valid = (ex_rd_i != '0);

    // compare destination with each source
    assign rs1_hit = (ex_rd_i == id_rs1_i);
    assign rs2_hit = (ex_rd_i == id_rs2_i);

    // only a load leaves its result late enough to need a bubble
    assign stall_flag_o = ex_is_load_i & rd_valid & (rs1_hit | rs2_hit);

endmodule

/* verilog/pc_reg.sv */
// fetch program counter
module pc_reg
    import pipe_ctrl_pkg::*;
#(
    parameter inst_addr_t RESET_ADDR = 32'h0000_0000
) (
    input  logic       clk,
    input  logic       reset_i,

    // redirect from ctrl
    input  logic       jump_flag_i,
    input  inst_addr_t jump_addr_i,

    // CU_STALL bit of the control bus
    input  logic       hold_i,

    output inst_addr_t pc_o
);

    inst_addr_t pc_q;

    // priority: reset, jump, hold, step
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= RESET_ADDR;
        end else if (jump_flag_i) begin
            // a jump beats any stall
            pc_q <= jump_addr_i;
        end else if (hold_i) begin
            pc_q <= pc_q;
        end else begin
            pc_q <= pc_q + INST_BYTES;
        end
    end

    assign pc_o = pc_q;

endmodule

/* verilog/pipe_ctrl_pkg.sv */
// pipeline control shared definitions
package pipe_ctrl_pkg;

    // basic widths
    localparam int INST_ADDR_WIDTH = 32;
    localparam int REG_IDX_WIDTH   = 5;
    localparam int CU_BUS_WIDTH    = 3;

    // instruction address, one word
    typedef logic [INST_ADDR_WIDTH-1:0] inst_addr_t;

    // architectural register index
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

    // pipeline control bus
    typedef logic [CU_BUS_WIDTH-1:0] cu_bus_t;

    // control bus bit positions
    // hold fetch and decode
    localparam int CU_STALL          = 0;
    // kill younger stages
    localparam int CU_FLUSH          = 1;
    // hold dispatch
    localparam int CU_STALL_DISPATCH = 2;

    // fetch step in bytes
    localparam inst_addr_t INST_BYTES = 32'd4;

    // interrupt sequencer states
    typedef enum logic [1:0] {
        CLINT_IDLE  = 2'd0,
        CLINT_FLUSH = 2'd1,
        CLINT_JUMP  = 2'd2
    } clint_state_t;

endpackage
